/* rename_pkg.sv */
package rename_pkg;

  //////////////////////////////////////////////////
  // sizes
  //////////////////////////////////////////////////
  localparam int num_lregs  = 32;  // architectural registers
  localparam int num_pregs  = 64;  // physical registers
  localparam int rob_depth  = 16;
  localparam int free_depth = 32;  // free after reset

  // pointer and counter widths
  localparam int free_idx_w = $clog2(free_depth);
  localparam int free_cnt_w = free_idx_w + 1;
  localparam int rob_cnt_w  = $clog2(rob_depth) + 1;

  //////////////////////////////////////////////////
  // register numbers
  //////////////////////////////////////////////////
  typedef logic [$clog2(num_lregs)-1:0] lreg_t;
  typedef logic [$clog2(num_pregs)-1:0] preg_t;
  typedef logic [$clog2(rob_depth)-1:0] rob_idx_t;
  typedef logic [5:0]                   opcode_t;

  // opcodes seen by rename
  localparam opcode_t op_rtype = 6'h00;  // writes rd
  localparam opcode_t op_beq   = 6'h04;
  localparam opcode_t op_addi  = 6'h08;  // writes rt
  localparam opcode_t op_lw    = 6'h23;  // writes rt
  localparam opcode_t op_sw    = 6'h2b;

  //////////////////////////////////////////////////
  // instruction word
  //////////////////////////////////////////////////
  typedef struct packed {
    opcode_t    opcode;
    lreg_t      rs;
    lreg_t      rt;
    lreg_t      rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_fields_t;

  typedef struct packed {
    opcode_t     opcode;
    lreg_t       rs;
    lreg_t       rt;   // destination for addi and lw
    logic [15:0] imm;
  } i_fields_t;

  // same 32 bits seen as either format
  typedef union packed {
    r_fields_t r;
    i_fields_t i;
  } instr_u;

endpackage

/* opcode_decoder.sv */
module opcode_decoder (
  input  rename_pkg::opcode_t i_opcode,
  output logic                o_valid,
  output logic                o_write_rd,
  output logic                o_reg_dest,
  output logic                o_read_rs,
  output logic                o_read_rt
);

  always_comb begin
    // unknown opcode never dispatches
    o_valid    = 1'b0;
    o_write_rd = 1'b0;
    o_reg_dest = 1'b0;
    o_read_rs  = 1'b0;
    o_read_rt  = 1'b0;

    case (i_opcode)
      rename_pkg::op_rtype: begin
        o_valid    = 1'b1;
        o_write_rd = 1'b1;  // dest in rd field
        o_reg_dest = 1'b1;
        o_read_rs  = 1'b1;
        o_read_rt  = 1'b1;
      end
      rename_pkg::op_addi,
      rename_pkg::op_lw: begin
        o_valid    = 1'b1;
        o_reg_dest = 1'b1;  // dest in rt field
        o_read_rs  = 1'b1;
      end
      rename_pkg::op_sw,
      rename_pkg::op_beq: begin
        // two sources, nothing written
        o_valid   = 1'b1;
        o_read_rs = 1'b1;
        o_read_rt = 1'b1;
      end
      default: begin
        o_valid = 1'b0;
      end
    endcase
  end

endmodule

/* map_table.sv */
module map_table (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_accept,
  input  logic              i_reg_dest,
  input  rename_pkg::lreg_t i_lrs,
  input  rename_pkg::lreg_t i_lrt,
  input  rename_pkg::lreg_t i_lrd,
  input  rename_pkg::preg_t i_p_rd_new,
  input  logic              i_compl_set,
  input  rename_pkg::preg_t i_compl_preg,
  input  logic              i_restore,
  input  rename_pkg::lreg_t i_restore_lrd,
  input  rename_pkg::preg_t i_restore_preg,
  output rename_pkg::preg_t o_p_rs,
  output rename_pkg::preg_t o_p_rt,
  output rename_pkg::preg_t o_p_rd_old,
  output logic              o_rs_ready,
  output logic              o_rt_ready
);

  rename_pkg::preg_t                  map [rename_pkg::num_lregs];
  logic [rename_pkg::num_pregs-1:0]   ready;

  logic rename_en;

  assign rename_en = i_accept && i_reg_dest;

  //////////////////////////////////////////////////
  // lookup in the dispatch cycle
  //////////////////////////////////////////////////
  assign o_p_rs     = map[i_lrs];
  assign o_p_rt     = map[i_lrt];
  assign o_p_rd_old = map[i_lrd];  // kept by the rob for undo and free

  // no bypass, a completion shows up one cycle later
  assign o_rs_ready = ready[o_p_rs];
  assign o_rt_ready = ready[o_p_rt];

  //////////////////////////////////////////////////
  // speculative map
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < rename_pkg::num_lregs; i++) begin
        map[i] <= rename_pkg::preg_t'(i);  // identity
      end
    end else begin
      if (rename_en) begin
        map[i_lrd] <= i_p_rd_new;
      end
      // recovery walk, never in a dispatch cycle
      if (i_restore) begin
        map[i_restore_lrd] <= i_restore_preg;
      end
    end
  end

  //////////////////////////////////////////////////
  // ready bits per physical register
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      ready <= '1;
    end else begin
      if (rename_en) begin
        ready[i_p_rd_new] <= 1'b0;  // value not produced yet
      end
      if (i_compl_set) begin
        ready[i_compl_preg] <= 1'b1;
      end
    end
  end

endmodule

/* free_list.sv */
module free_list (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_pop,
  input  logic              i_push,
  input  rename_pkg::preg_t i_push_preg,
  output rename_pkg::preg_t o_head,
  output logic              o_empty
);

  rename_pkg::preg_t                    fifo [rename_pkg::free_depth];
  logic [rename_pkg::free_idx_w-1:0]    head;
  logic [rename_pkg::free_idx_w-1:0]    tail;
  logic [rename_pkg::free_cnt_w-1:0]    count;

  logic do_pop;

  // never pop past empty
  assign do_pop  = i_pop && !o_empty;
  assign o_head  = fifo[head];
  assign o_empty = (count == '0);

  //////////////////////////////////////////////////
  // queue storage
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      // registers above the architectural ones start free
      for (int i = 0; i < rename_pkg::free_depth; i++) begin
        fifo[i] <= rename_pkg::preg_t'(rename_pkg::num_lregs + i);
      end
    end else if (i_push) begin
      fifo[tail] <= i_push_preg;
    end
  end

  //////////////////////////////////////////////////
  // pointers
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      head <= '0;
      tail <= '0;  // wraps onto head, list is full
    end else begin
      if (do_pop) begin
        head <= head + 1'b1;
      end
      if (i_push) begin
        tail <= tail + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      count <= rename_pkg::free_cnt_w'(rename_pkg::free_depth);
    end else begin
      case ({do_pop, i_push})
        2'b10:   count <= count - 1'b1;
        2'b01:   count <= count + 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

endmodule

/* reorder_buffer.sv */
module reorder_buffer (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 i_dispatch,
  input  logic                 i_valid_op,
  input  logic                 i_reg_dest,
  input  logic                 i_free_empty,
  input  rename_pkg::lreg_t    i_lrd,
  input  rename_pkg::preg_t    i_p_rd_new,
  input  rename_pkg::preg_t    i_p_rd_old,
  input  logic                 i_complete,
  input  logic                 i_mispredict,
  input  rename_pkg::rob_idx_t i_compl_rob,
  output logic                 o_accept,
  output logic                 o_stall,
  output rename_pkg::rob_idx_t o_rob_num,
  output logic                 o_compl_set,
  output rename_pkg::preg_t    o_compl_preg,
  output logic                 o_retire,
  output rename_pkg::lreg_t    o_retire_lrd,
  output rename_pkg::preg_t    o_retire_p_rd,
  output logic                 o_free_push,
  output rename_pkg::preg_t    o_free_preg,
  output logic                 o_restore,
  output rename_pkg::lreg_t    o_restore_lrd,
  output rename_pkg::preg_t    o_restore_preg
);

  // entry fields
  logic [rename_pkg::rob_depth-1:0] dest;
  logic [rename_pkg::rob_depth-1:0] done;
  rename_pkg::lreg_t                lrd   [rename_pkg::rob_depth];
  rename_pkg::preg_t                p_old [rename_pkg::rob_depth];
  rename_pkg::preg_t                p_new [rename_pkg::rob_depth];

  rename_pkg::rob_idx_t             head;
  rename_pkg::rob_idx_t             tail;
  rename_pkg::rob_idx_t             tail_m1;  // youngest entry
  logic [rename_pkg::rob_cnt_w-1:0] count;
  logic [rename_pkg::rob_cnt_w-1:0] count_nxt;

  logic                 rec_active;
  rename_pkg::rob_idx_t rec_target;  // tail value when the walk ends
  logic                 walk;
  logic                 full;

  assign tail_m1 = tail - 1'b1;
  assign full    = (count == rename_pkg::rob_cnt_w'(rename_pkg::rob_depth));
  assign walk    = rec_active && (tail != rec_target);

  //////////////////////////////////////////////////
  // dispatch decision
  //////////////////////////////////////////////////
  assign o_stall   = full || walk || (i_reg_dest && i_free_empty);
  assign o_accept  = i_dispatch && i_valid_op && !o_stall;
  assign o_rob_num = tail;

  // completion looks up the register to mark ready
  assign o_compl_set  = i_complete && dest[i_compl_rob];
  assign o_compl_preg = p_new[i_compl_rob];

  // in order, held off while a recovery is pending
  assign o_retire      = (count != '0) && done[head] && !rec_active;
  assign o_retire_lrd  = lrd[head];
  assign o_retire_p_rd = p_new[head];

  //////////////////////////////////////////////////
  // recovery walk, one youngest entry per cycle
  //////////////////////////////////////////////////
  assign o_restore      = walk && dest[tail_m1];
  assign o_restore_lrd  = lrd[tail_m1];
  assign o_restore_preg = p_old[tail_m1];

  // retire and walk never overlap
  assign o_free_push = walk ? dest[tail_m1] : (o_retire && dest[head]);
  assign o_free_preg = walk ? p_new[tail_m1] : p_old[head];

  always_comb begin
    count_nxt = count;
    if (o_accept) count_nxt = count_nxt + 1'b1;
    if (o_retire) count_nxt = count_nxt - 1'b1;
    if (walk)     count_nxt = count_nxt - 1'b1;
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      count <= count_nxt;
      if (o_accept) tail <= tail + 1'b1;
      if (walk)     tail <= tail_m1;
      if (o_retire) head <= head + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      rec_active <= 1'b0;
      rec_target <= '0;
    end else if (i_complete && i_mispredict && !rec_active) begin
      rec_active <= 1'b1;
      rec_target <= i_compl_rob + 1'b1;  // branch entry itself stays
    end else if (rec_active && (!walk || tail_m1 == rec_target)) begin
      rec_active <= 1'b0;  // last undo at this edge
    end
  end

  //////////////////////////////////////////////////
  // entry flags
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      dest <= '0;
      done <= '0;
    end else begin
      if (o_accept) begin
        dest[tail] <= i_reg_dest;
        done[tail] <= 1'b0;
      end
      if (i_complete) begin
        done[i_compl_rob] <= 1'b1;
      end
    end
  end

  // payload written at dispatch
  always_ff @(posedge clk) begin
    if (o_accept) begin
      lrd[tail]   <= i_lrd;
      p_old[tail] <= i_p_rd_old;
      p_new[tail] <= i_p_rd_new;
    end
  end

endmodule

/* rename_core.sv */
module rename_core (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 i_dispatch,
  input  rename_pkg::instr_u   i_instr,
  input  logic                 i_complete,
  input  logic                 i_compl_mispredict,
  input  rename_pkg::rob_idx_t i_compl_rob,
  output logic                 o_stall,
  output rename_pkg::rob_idx_t o_rob_num,
  output rename_pkg::preg_t    o_p_rs,
  output rename_pkg::preg_t    o_p_rt,
  output rename_pkg::preg_t    o_p_rd_new,
  output logic                 o_rs_ready,
  output logic                 o_rt_ready,
  output logic                 o_retire,
  output rename_pkg::lreg_t    o_retire_lrd,
  output rename_pkg::preg_t    o_retire_p_rd
);

  // decode
  logic valid_op, write_rd, reg_dest, read_rs, read_rt;
  rename_pkg::lreg_t l_rd;

  // map table
  logic              rs_ready_map, rt_ready_map;
  rename_pkg::preg_t p_rd_old;

  // free list
  rename_pkg::preg_t free_head;
  logic              free_empty;

  // rob side
  logic              accept;
  logic              compl_set, free_push, restore;
  rename_pkg::preg_t compl_preg, free_preg, restore_preg;
  rename_pkg::lreg_t restore_lrd;

  //////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////
  opcode_decoder i_opcode_decoder (
    .i_opcode   (i_instr.r.opcode),
    .o_valid    (valid_op),
    .o_write_rd (write_rd),
    .o_reg_dest (reg_dest),
    .o_read_rs  (read_rs),
    .o_read_rt  (read_rt)
  );

  // r-type writes rd, immediate forms write rt
  assign l_rd = write_rd ? i_instr.r.rd : i_instr.i.rt;

  assign o_p_rd_new = free_head;
  // an operand that is not read never waits
  assign o_rs_ready = rs_ready_map || !read_rs;
  assign o_rt_ready = rt_ready_map || !read_rt;

  map_table i_map_table (
    .clk            (clk),
    .rst            (rst),
    .i_accept       (accept),
    .i_reg_dest     (reg_dest),
    .i_lrs          (i_instr.r.rs),
    .i_lrt          (i_instr.r.rt),
    .i_lrd          (l_rd),
    .i_p_rd_new     (free_head),
    .i_compl_set    (compl_set),
    .i_compl_preg   (compl_preg),
    .i_restore      (restore),
    .i_restore_lrd  (restore_lrd),
    .i_restore_preg (restore_preg),
    .o_p_rs         (o_p_rs),
    .o_p_rt         (o_p_rt),
    .o_p_rd_old     (p_rd_old),
    .o_rs_ready     (rs_ready_map),
    .o_rt_ready     (rt_ready_map)
  );

  free_list i_free_list (
    .clk         (clk),
    .rst         (rst),
    .i_pop       (accept && reg_dest),
    .i_push      (free_push),
    .i_push_preg (free_preg),
    .o_head      (free_head),
    .o_empty     (free_empty)
  );

  reorder_buffer i_reorder_buffer (
    .clk            (clk),
    .rst            (rst),
    .i_dispatch     (i_dispatch),
    .i_valid_op     (valid_op),
    .i_reg_dest     (reg_dest),
    .i_free_empty   (free_empty),
    .i_lrd          (l_rd),
    .i_p_rd_new     (free_head),
    .i_p_rd_old     (p_rd_old),
    .i_complete     (i_complete),
    .i_mispredict   (i_compl_mispredict),
    .i_compl_rob    (i_compl_rob),
    .o_accept       (accept),
    .o_stall        (o_stall),
    .o_rob_num      (o_rob_num),
    .o_compl_set    (compl_set),
    .o_compl_preg   (compl_preg),
    .o_retire       (o_retire),
    .o_retire_lrd   (o_retire_lrd),
    .o_retire_p_rd  (o_retire_p_rd),
    .o_free_push    (free_push),
    .o_free_preg    (free_preg),
    .o_restore      (restore),
    .o_restore_lrd  (restore_lrd),
    .o_restore_preg (restore_preg)
  );

endmodule

/* tb_rename_core.sv */
module tb_rename_core;
  timeunit 1ns;
  timeprecision 100ps;

  typedef enum logic [2:0] {act_disp, act_try, act_comp, act_misp, act_idle} act_e;

  typedef struct {
    act_e                 act;
    rename_pkg::instr_u   word;
    rename_pkg::rob_idx_t rob;
    int                   n;     // idle length
  } row_t;

  logic                 clk, rst;
  logic                 i_dispatch, i_complete, i_compl_mispredict;
  rename_pkg::instr_u   i_instr;
  rename_pkg::rob_idx_t i_compl_rob;
  logic                 o_stall, o_rs_ready, o_rt_ready, o_retire;
  rename_pkg::rob_idx_t o_rob_num;
  rename_pkg::preg_t    o_p_rs, o_p_rt, o_p_rd_new, o_retire_p_rd;
  rename_pkg::lreg_t    o_retire_lrd;

  // reference model state
  rename_pkg::preg_t                m_map [rename_pkg::num_lregs];
  logic [rename_pkg::num_pregs-1:0] m_ready;
  rename_pkg::preg_t                m_free [$];
  logic [rename_pkg::rob_depth-1:0] m_dest, m_done;
  rename_pkg::lreg_t                m_lrd [rename_pkg::rob_depth];
  rename_pkg::preg_t                m_old [rename_pkg::rob_depth];
  rename_pkg::preg_t                m_new [rename_pkg::rob_depth];
  rename_pkg::rob_idx_t             m_head, m_tail, m_target;
  int                               m_count;
  logic                             m_rec;

  row_t table_q [$];
  int   cycles;
  int   limit = 0;

  rename_core i_rename_core (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // watchdog
  initial begin
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (limit > 0 && cycles > limit) begin
        $display("timeout: run went past %0d cycles", limit);
        $display("tests failed");
        $fatal(1, "watchdog expired");
      end
    end
  end

  //////////////////////////////////////////////////
  // checking
  //////////////////////////////////////////////////
  task automatic report_failure(input string what);
    $display("%s", what);
    $display("tests failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare_preg(input string name, input rename_pkg::preg_t act,
                              input rename_pkg::preg_t exp);
    if (act !== exp)
      report_failure($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, act, exp));
  endtask

  task automatic compare_lreg(input string name, input rename_pkg::lreg_t act,
                              input rename_pkg::lreg_t exp);
    if (act !== exp)
      report_failure($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, act, exp));
  endtask

  task automatic compare_rob(input string name, input rename_pkg::rob_idx_t act,
                             input rename_pkg::rob_idx_t exp);
    if (act !== exp)
      report_failure($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, act, exp));
  endtask

  task automatic compare_bit(input string name, input logic act, input logic exp);
    if (act !== exp)
      report_failure($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, act, exp));
  endtask

  // {valid, write_rd, reg_dest, read_rs, read_rt}
  function automatic logic [4:0] rename_controls(input rename_pkg::opcode_t op);
    case (op)
      rename_pkg::op_rtype:                  return 5'b11111;
      rename_pkg::op_addi, rename_pkg::op_lw: return 5'b10110;
      rename_pkg::op_sw, rename_pkg::op_beq:  return 5'b10011;
      default:                               return 5'b00000;
    endcase
  endfunction

  task automatic reset_model();
    m_free.delete();
    for (int i = 0; i < rename_pkg::num_lregs; i++) m_map[i] = rename_pkg::preg_t'(i);
    for (int i = 0; i < rename_pkg::free_depth; i++)
      m_free.push_back(rename_pkg::preg_t'(rename_pkg::num_lregs + i));
    m_ready  = '1;
    m_dest   = '0;
    m_done   = '0;
    m_head   = '0;
    m_tail   = '0;
    m_target = '0;
    m_count  = 0;
    m_rec    = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // one clock cycle of drive, check and model update
  //////////////////////////////////////////////////
  task automatic run_cycle(input logic disp, input rename_pkg::instr_u w, input logic comp,
                           input logic misp, input rename_pkg::rob_idx_t crob,
                           output logic accepted);
    logic                 valid_op, write_rd, reg_dest, read_rs, read_rt;
    logic                 walk, stall, acc, ret, free_empty;
    rename_pkg::lreg_t    lrd;
    rename_pkg::preg_t    p_rs, p_rt;
    rename_pkg::rob_idx_t tail_m1;
    @(posedge clk);
    #10;
    i_dispatch         = disp;
    i_instr            = w;
    i_complete         = comp;
    i_compl_mispredict = misp;
    i_compl_rob        = crob;
    #70;  // outputs settled well before the next edge
    {valid_op, write_rd, reg_dest, read_rs, read_rt} = rename_controls(w.r.opcode);
    lrd        = write_rd ? w.r.rd : w.i.rt;
    p_rs       = m_map[w.r.rs];
    p_rt       = m_map[w.r.rt];
    tail_m1    = m_tail - 1'b1;
    free_empty = (m_free.size() == 0);
    walk       = m_rec && (m_tail != m_target);
    stall      = (m_count == rename_pkg::rob_depth) || walk || (reg_dest && free_empty);
    acc        = disp && valid_op && !stall;
    ret        = (m_count != 0) && m_done[m_head] && !m_rec;

    compare_bit("o_stall", o_stall, stall);
    if (disp) compare_rob("o_rob_num", o_rob_num, m_tail);
    if (acc) begin
      compare_preg("o_p_rs", o_p_rs, p_rs);
      compare_preg("o_p_rt", o_p_rt, p_rt);
      compare_bit("o_rs_ready", o_rs_ready, m_ready[p_rs] || !read_rs);
      compare_bit("o_rt_ready", o_rt_ready, m_ready[p_rt] || !read_rt);
      if (reg_dest) compare_preg("o_p_rd_new", o_p_rd_new, m_free[0]);
    end
    compare_bit("o_retire", o_retire, ret);
    if (ret && m_dest[m_head]) begin
      compare_lreg("o_retire_lrd", o_retire_lrd, m_lrd[m_head]);
      compare_preg("o_retire_p_rd", o_retire_p_rd, m_new[m_head]);
    end

    if (acc) begin
      m_dest[m_tail] = reg_dest;
      m_done[m_tail] = 1'b0;
      m_lrd[m_tail]  = lrd;
      m_old[m_tail]  = m_map[lrd];  // read before remap
      m_new[m_tail]  = reg_dest ? m_free[0] : '0;
      if (reg_dest) begin
        m_map[lrd]               = m_free.pop_front();
        m_ready[m_new[m_tail]]   = 1'b0;
      end
      m_tail  = m_tail + 1'b1;
      m_count = m_count + 1;
    end
    if (comp) begin
      if (m_dest[crob]) m_ready[m_new[crob]] = 1'b1;
      m_done[crob] = 1'b1;
    end
    if (ret) begin
      if (m_dest[m_head]) m_free.push_back(m_old[m_head]);
      m_head  = m_head + 1'b1;
      m_count = m_count - 1;
    end
    if (walk) begin
      if (m_dest[tail_m1]) begin
        m_map[m_lrd[tail_m1]] = m_old[tail_m1];
        m_free.push_back(m_new[tail_m1]);
      end
      m_tail  = tail_m1;
      m_count = m_count - 1;
    end
    if (comp && misp && !m_rec) begin
      m_rec    = 1'b1;
      m_target = crob + 1'b1;
    end else if (m_rec && (!walk || tail_m1 == m_target)) begin
      m_rec = 1'b0;
    end
    // the source sees the DUT's own stall
    accepted = disp && valid_op && !o_stall;
  endtask

  //////////////////////////////////////////////////
  // stimulus table
  //////////////////////////////////////////////////
  function automatic rename_pkg::instr_u make_r(input rename_pkg::lreg_t rd,
      input rename_pkg::lreg_t rs, input rename_pkg::lreg_t rt);
    rename_pkg::instr_u w;
    w          = '0;
    w.r.opcode = rename_pkg::op_rtype;
    w.r.rs     = rs;
    w.r.rt     = rt;
    w.r.rd     = rd;
    return w;
  endfunction

  function automatic rename_pkg::instr_u make_i(input rename_pkg::opcode_t op,
      input rename_pkg::lreg_t rt, input rename_pkg::lreg_t rs);
    rename_pkg::instr_u w;
    w          = '0;
    w.i.opcode = op;
    w.i.rs     = rs;
    w.i.rt     = rt;
    w.i.imm    = 16'h0040;
    return w;
  endfunction

  function automatic rename_pkg::instr_u random_instr();
    rename_pkg::instr_u  w;
    rename_pkg::opcode_t ops [5];
    ops        = '{rename_pkg::op_rtype, rename_pkg::op_addi, rename_pkg::op_lw,
                   rename_pkg::op_sw, rename_pkg::op_beq};
    w          = $urandom;
    w.r.opcode = ops[$urandom % 5];
    return w;
  endfunction

  // always takes a register
  function automatic rename_pkg::instr_u random_rtype();
    rename_pkg::instr_u w;
    w          = $urandom;
    w.r.opcode = rename_pkg::op_rtype;
    return w;
  endfunction

  task automatic add_row(input act_e act, input rename_pkg::instr_u w,
                         input rename_pkg::rob_idx_t rob, input int n);
    row_t row;
    row.act  = act;
    row.word = w;
    row.rob  = rob;
    row.n    = n;
    table_q.push_back(row);
  endtask

  task automatic build_table();
    // fresh map, dependent sources, no-destination ops
    add_row(act_disp, make_r(5'd1, 5'd2, 5'd3), 4'd0, 0);  // rob 0
    add_row(act_disp, make_r(5'd4, 5'd5, 5'd6), 4'd0, 0);
    add_row(act_disp, make_r(5'd7, 5'd1, 5'd4), 4'd0, 0);  // both sources pending
    add_row(act_comp, '0, 4'd0, 0);
    add_row(act_disp, make_r(5'd8, 5'd1, 5'd9), 4'd0, 0);
    add_row(act_disp, make_i(rename_pkg::op_sw, 5'd8, 5'd1), 4'd0, 0);
    add_row(act_disp, make_i(rename_pkg::op_beq, 5'd8, 5'd7), 4'd0, 0);
    add_row(act_disp, make_i(rename_pkg::op_addi, 5'd10, 5'd1), 4'd0, 0);  // rob 6
    for (int k = 1; k < 7; k++) add_row(act_comp, '0, rename_pkg::rob_idx_t'(k), 0);
    add_row(act_idle, '0, 4'd0, 4);
    // fill all 16 entries from rob 7 around to rob 6
    for (int k = 0; k < 16; k++) add_row(act_disp, random_instr(), 4'd0, 0);
    add_row(act_try, random_instr(), 4'd0, 0);
    add_row(act_comp, '0, 4'd7, 0);
    add_row(act_idle, '0, 4'd0, 1);
    add_row(act_disp, random_instr(), 4'd0, 0);
    // oldest entry mispredicts and its 15 younger ones are undone
    add_row(act_misp, '0, 4'd8, 0);
    add_row(act_disp, random_instr(), 4'd0, 0);  // rob 9
    add_row(act_disp, make_i(rename_pkg::op_beq, 5'd2, 5'd1), 4'd0, 0);  // rob 10
    add_row(act_disp, make_r(5'd1, 5'd2, 5'd3), 4'd0, 0);
    add_row(act_disp, make_i(rename_pkg::op_lw, 5'd2, 5'd1), 4'd0, 0);
    add_row(act_misp, '0, 4'd10, 0);
    add_row(act_disp, make_r(5'd3, 5'd1, 5'd2), 4'd0, 0);  // sees pre-branch map
    add_row(act_comp, '0, 4'd9, 0);
    add_row(act_comp, '0, 4'd11, 0);
    add_row(act_idle, '0, 4'd0, 6);
    // steady flow long enough to hand out every recycled register
    for (int k = 0; k < rename_pkg::free_depth; k++) begin
      add_row(act_disp, random_rtype(), 4'd0, 0);
      add_row(act_comp, '0, rename_pkg::rob_idx_t'(12 + k), 0);
    end
    add_row(act_idle, '0, 4'd0, 4);
  endtask

  task automatic apply_row(input row_t row);
    logic                 accepted;
    int                   wait_max;
    int                   waited;
    rename_pkg::rob_idx_t gap;
    wait_max = 0;
    waited   = 0;
    case (row.act)
      act_disp: begin
        gap = m_tail - m_target;  // walk cycles still to come
        if (m_rec) wait_max = int'(gap);
        run_cycle(1'b1, row.word, 1'b0, 1'b0, '0, accepted);
        while (!accepted) begin
          waited++;
          if (waited > wait_max)
            report_failure($sformatf("dispatch still stalled after %0d cycles", waited));
          run_cycle(1'b1, row.word, 1'b0, 1'b0, '0, accepted);
        end
        if (waited != wait_max)
          report_failure($sformatf("stall lasted %0d cycles instead of %0d", waited, wait_max));
      end
      act_try: begin
        run_cycle(1'b1, row.word, 1'b0, 1'b0, '0, accepted);
        if (accepted) report_failure("dispatch was taken while the ROB was full");
      end
      act_comp: run_cycle(1'b0, '0, 1'b1, 1'b0, row.rob, accepted);
      act_misp: run_cycle(1'b0, '0, 1'b1, 1'b1, row.rob, accepted);
      default:  repeat (row.n) run_cycle(1'b0, '0, 1'b0, 1'b0, '0, accepted);
    endcase
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////
  initial begin
    rst                = 1'b0;
    i_dispatch         = 1'b0;
    i_instr            = '0;
    i_complete         = 1'b0;
    i_compl_mispredict = 1'b0;
    i_compl_rob        = '0;
    void'($urandom(56));
    build_table();
    limit = 20 * table_q.size() + 100;
    reset_model();
    repeat (5) @(posedge clk);
    #10;
    rst = 1'b1;
    foreach (table_q[k]) apply_row(table_q[k]);
    $display("all tests passed");
    $finish;
  end

endmodule

/* src.f */
rename_pkg.sv
opcode_decoder.sv
map_table.sv
free_list.sv
reorder_buffer.sv
rename_core.sv
tb_rename_core.sv

/* run.sh */
#!/bin/sh
# compile with Verilator and run, exit status follows the simulation
verilator --binary --timing -Wno-fatal -f src.f --top-module tb_rename_core -o sim_rename \
  && ./obj_dir/sim_rename \
  || exit 1
